// File: compile.f
design/cpu_bus_pkg.sv
design/accum_cpu.sv
design/byte_bus_sequencer.sv
design/cpuhandler_top.sv
verification/cpuhandler_asserts.sv
verification/tb_byte_memory.sv
verification/tb_cpuhandler.sv

// File: design/accum_cpu.sv
// Accumulator CPU with a fetch/execute FSM issuing one bus request per step
module accum_cpu
  import cpu_bus_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     step,   // High in phase 0, the CPU moves at its end
  input  word_t    rdata,  // Read data of the frame that just ended
  output bus_req_t req     // Held stable from one step to the next
);

  cpu_state_t state;
  cpu_state_t state_d;
  logic       primed;    // First fetch has gone out
  word_t      pc;
  word_t      pc_d;
  word_t      acc;
  word_t      acc_d;
  word_t      ir;        // Instruction being executed
  bus_req_t   req_d;
  opcode_t    fetch_op;  // Opcode arriving on rdata
  opcode_t    exec_op;   // Opcode held in ir
  word_t      pc_inc;
  word_t      target;    // Jump target from the ir operand

  // Operand field zero-extended to a full word
  function automatic word_t operand(input word_t instr);
    return {8'h00, instr[23:0]};
  endfunction

  function automatic bus_req_t read_req(input word_t addr);
    bus_req_t r;
    r.addr  = addr;
    r.wdata = '0;
    r.write = 1'b0;
    return r;
  endfunction

  function automatic bus_req_t write_req(input word_t addr, input word_t data);
    bus_req_t r;
    r.addr  = addr;
    r.wdata = data;
    r.write = 1'b1;
    return r;
  endfunction

  // Memory-operand ALU, LD passes the memory word through
  function automatic word_t alu(input opcode_t op, input word_t a, input word_t m);
    case (op)
      ADD:     return a + m;
      SUB:     return a - m;
      AND:     return a & m;
      XOR:     return a ^ m;
      default: return m;
    endcase
  endfunction

  // Unknown codes fall through the decoders as no-ops
  assign fetch_op = opcode_t'(rdata[31:24]);
  assign exec_op  = opcode_t'(ir[31:24]);
  assign pc_inc   = pc + 32'd1;
  assign target   = operand(ir);

  always_comb begin
    state_d = state;
    pc_d    = pc;
    acc_d   = acc;
    req_d   = req;

    if (!primed) begin
      req_d = read_req(pc);  // Very first fetch, nothing to consume yet
    end else begin
      case (state)
        FETCH: begin
          state_d = EXECUTE;
          case (fetch_op)
            LD, ADD, SUB, AND, XOR: req_d = read_req(operand(rdata));
            ST:                     req_d = write_req(operand(rdata), acc);
            default:                req_d = read_req(pc);  // Idle read
          endcase
        end

        EXECUTE: begin
          state_d = FETCH;
          pc_d    = pc_inc;
          case (exec_op)
            LDI: acc_d = operand(ir);
            LD, ADD, SUB, AND, XOR: acc_d = alu(exec_op, acc, rdata);
            JMP: pc_d = target;
            JZ: begin
              if (acc == '0) begin
                pc_d = target;  // Taken
              end
            end
            HALT: begin
              state_d = HALTED;
              pc_d    = pc;  // Parked on the HALT word
            end
            default: ;  // ST and no-ops only advance pc
          endcase
          req_d = read_req(pc_d);  // Next fetch, or idle read once halted
        end

        default: begin
          req_d = read_req(pc);  // HALTED keeps reading at pc
        end
      endcase
    end
  end

  // Everything moves on the edge that ends phase 0
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= FETCH;
      primed <= 1'b0;
      pc     <= '0;
      acc    <= '0;
      req    <= '0;
    end else if (step) begin
      state  <= state_d;
      primed <= 1'b1;
      pc     <= pc_d;
      acc    <= acc_d;
      req    <= req_d;
    end
  end

  // The fetch frame's read data is the instruction word
  always_ff @(posedge clk) begin
    if (step && primed && state == FETCH) begin
      ir <= rdata;
    end
  end

endmodule

// File: design/byte_bus_sequencer.sv
// Nine-phase frame sequencer that serializes a bus request over byte-wide pins
module byte_bus_sequencer
  import cpu_bus_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  bus_req_t req,      // Stable for the whole frame
  output word_t    rdata,    // Bytes captured in phases 5 to 8
  output logic     step,     // One cycle per frame, phase 0
  output byte_t    uo_out,   // Address bytes, LSB first
  output byte_t    uio_out,  // Write data bytes, LSB first
  output byte_t    uio_oe,   // All ones in a write frame
  input  byte_t    uio_in    // Read data bytes, LSB first
);

  phase_t     phase;
  logic       last_phase;
  logic       send_phase;  // Phases 1 to 4
  logic       recv_phase;  // Phases 5 to 8
  logic [1:0] byte_sel;

  // Byte idx of a word, idx 0 is the least significant
  function automatic byte_t byte_of(input word_t w, input logic [1:0] idx);
    return w[{idx, 3'b000} +: 8];
  endfunction

  assign last_phase = (phase == phase_t'(FRAME_PHASES - 1));
  assign send_phase = (phase >= 4'd1) && (phase <= 4'd4);
  assign recv_phase = (phase >= 4'd5) && (phase <= 4'd8);
  assign byte_sel   = phase[1:0] - 2'd1;  // Phase 1..4 maps to byte 0..3

  assign step = (phase == '0);

  // Counts 0 to 8 and wraps, with no skipped values
  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= '0;
    end else if (last_phase) begin
      phase <= '0;
    end else begin
      phase <= phase + 4'd1;
    end
  end

  // Byte k-1 loads at the end of phase k and shows during the next phase
  always_ff @(posedge clk) begin
    if (reset) begin
      uo_out  <= '0;
      uio_out <= '0;
    end else if (send_phase) begin
      uo_out  <= byte_of(req.addr, byte_sel);
      uio_out <= byte_of(req.wdata, byte_sel);
    end
  end

  // Shift in from the top so the phase 5 byte ends up in bits 7:0
  always_ff @(posedge clk) begin
    if (recv_phase) begin
      rdata <= {uio_in, rdata[31:8]};
    end
  end

  // req only changes at the end of phase 0, so the enable does too
  assign uio_oe = req.write ? 8'hff : 8'h00;

endmodule

// File: design/cpu_bus_pkg.sv
// Bus widths, frame length, opcode and CPU state enums, bus request struct
package cpu_bus_pkg;

  typedef logic [31:0] word_t;   // Data, address and instruction word
  typedef logic [7:0]  byte_t;   // One pin byte
  typedef logic [3:0]  phase_t;  // Frame phase number

  // Clock cycles per bus frame, phase 0 is the CPU step
  localparam int FRAME_PHASES = 9;

  // Opcode sits in bits 31:24, operand in bits 23:0
  typedef enum logic [7:0] {
    LDI  = 8'h10,  // acc = operand
    LD   = 8'h11,  // acc = mem[operand]
    ADD  = 8'h20,  // acc = acc + mem[operand]
    SUB  = 8'h21,  // acc = acc - mem[operand]
    AND  = 8'h22,  // acc = acc & mem[operand]
    XOR  = 8'h23,  // acc = acc ^ mem[operand]
    ST   = 8'h30,  // mem[operand] = acc
    JMP  = 8'h40,  // pc = operand
    JZ   = 8'h41,  // pc = operand when acc is zero
    HALT = 8'hff   // Stop, idle reads at pc from then on
  } opcode_t;

  typedef enum logic [1:0] {
    FETCH,    // Next step latches the instruction
    EXECUTE,  // Next step retires the instruction
    HALTED
  } cpu_state_t;

  // One bus transaction, held for a whole frame
  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;
  } bus_req_t;

endpackage

// File: design/cpuhandler_top.sv
// Pin-level top connecting the accumulator CPU to the byte bus sequencer
module cpuhandler_top
  import cpu_bus_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  byte_t ui_in,    // Not used by this design
  output byte_t uo_out,   // Address bytes
  input  byte_t uio_in,   // Read data bytes
  output byte_t uio_out,  // Write data bytes
  output byte_t uio_oe,   // Bidirectional port enable
  input  logic  ena       // Not used by this design
);

  bus_req_t req;    // CPU to sequencer
  word_t    rdata;  // Sequencer to CPU
  logic     step;

  accum_cpu cpu_i (
    .clk   (clk),
    .reset (reset),
    .step  (step),
    .rdata (rdata),
    .req   (req)
  );

  byte_bus_sequencer seq_i (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .rdata   (rdata),
    .step    (step),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .uio_in  (uio_in)
  );

endmodule

// File: verification/cpuhandler_asserts.sv
// Bound checks on the sequencer pins: enable levels, enable timing and step spacing
module cpuhandler_asserts
  import cpu_bus_pkg::*;
(
  input logic   clk,
  input logic   reset,
  input phase_t phase,
  input logic   step,
  input byte_t  uio_oe
);

  int failures = 0;  // Failed assertion attempts so far

  // The bidirectional port turns around as a whole
  a_oe_levels: assert property (
    @(posedge clk) disable iff (reset)
    uio_oe == 8'h00 || uio_oe == 8'hff
  ) else begin
    failures++;
    $error("uio_oe is neither all ones nor all zeros");
  end

  // A change on the edge that ends phase 0 is first sampled in phase 1
  a_oe_timing: assert property (
    @(posedge clk) disable iff (reset)
    !reset && $changed(uio_oe) |-> phase == phase_t'(1)
  ) else begin
    failures++;
    $error("uio_oe changed outside the end of phase 0");
  end

  // One step cycle, then eight quiet ones, then the next step
  a_step_period: assert property (
    @(posedge clk) disable iff (reset)
    !reset && step |=> (!step) [*FRAME_PHASES - 1] ##1 step
  ) else begin
    failures++;
    $error("step is not a single cycle once every frame");
  end

endmodule

// File: verification/tb_byte_memory.sv
// Pin-level word memory that follows the nine-phase frame and serves reads and writes
module tb_byte_memory
  import cpu_bus_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  byte_t uo_out,       // Address bytes from the DUT
  input  byte_t uio_out,      // Write data bytes from the DUT
  input  byte_t uio_oe,
  output byte_t uio_in,       // Read data bytes to the DUT
  output int    frame_count,  // Frames whose address has been seen
  output word_t frame_addr,   // Address of the latest frame
  output word_t frame_wdata,  // Write data of the latest frame
  output byte_t frame_oe      // uio_oe seen in the latest frame
);

  word_t  mem [4096];  // Indexed by address bits 11:0
  phase_t phase;       // Local copy of the frame phase
  word_t  addr_q;
  word_t  wdata_q;
  word_t  rd_word;

  initial uio_in <= '0;

  // Filler words decode as no-ops, top byte stays below 8'h10
  task automatic clear_memory();
    for (int i = 0; i < 4096; i++) begin
      mem[i] <= 32'h00a5_0000 ^ (word_t'(i) * 32'h0001_0001);
    end
  endtask

  task automatic load_word(input word_t addr, input word_t data);
    mem[addr[11:0]] <= data;
  endtask

  function automatic word_t read_word(input word_t addr);
    return mem[addr[11:0]];
  endfunction

  // Byte k-1 of a frame is visible in phase k+1, so it is taken at that phase's end
  always @(posedge clk) begin
    if (reset) begin
      phase       <= '0;
      addr_q      <= '0;
      wdata_q     <= '0;
      rd_word     <= '0;
      uio_in      <= '0;
      frame_count <= 0;
      frame_addr  <= '0;
      frame_wdata <= '0;
      frame_oe    <= '0;
    end else begin
      phase <= (phase == phase_t'(FRAME_PHASES - 1)) ? '0 : phase + 4'd1;
      case (phase)
        4'd2: begin
          addr_q[7:0]  <= uo_out;
          wdata_q[7:0] <= uio_out;
        end
        4'd3: begin
          addr_q[15:8]  <= uo_out;
          wdata_q[15:8] <= uio_out;
        end
        4'd4: begin
          addr_q[23:16]  <= uo_out;
          wdata_q[23:16] <= uio_out;
          rd_word        <= mem[addr_q[11:0]];  // Index bytes are in already
          uio_in         <= mem[addr_q[11:0]][7:0];
        end
        4'd5: begin
          uio_in      <= rd_word[15:8];
          frame_addr  <= {uo_out, addr_q[23:0]};
          frame_wdata <= {uio_out, wdata_q[23:0]};
          frame_oe    <= uio_oe;
          frame_count <= frame_count + 1;
          if (uio_oe == 8'hff) begin
            mem[addr_q[11:0]] <= {uio_out, wdata_q[23:0]};  // Commit the write frame
          end
        end
        4'd6: uio_in <= rd_word[23:16];
        4'd7: uio_in <= rd_word[31:24];
        default: uio_in <= '0;
      endcase
    end
  end

endmodule

// File: verification/tb_cpuhandler.sv
// Testbench top with clock, reset, directed CPU programs, compare tasks and final report
module tb_cpuhandler
  import cpu_bus_pkg::*;
();

  logic  clk;
  logic  reset;
  byte_t ui_in;
  byte_t uo_out;
  byte_t uio_in;
  byte_t uio_out;
  byte_t uio_oe;
  logic  ena;
  int    frame_count;
  word_t frame_addr;
  word_t frame_wdata;
  byte_t frame_oe;
  int    errors;
  int    checks;
  int    timeouts;
  int    assert_failures;

  cpuhandler_top dut_i (
    .clk     (clk),
    .reset   (reset),
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena)
  );

  tb_byte_memory mem_i (
    .clk         (clk),
    .reset       (reset),
    .uo_out      (uo_out),
    .uio_out     (uio_out),
    .uio_oe      (uio_oe),
    .uio_in      (uio_in),
    .frame_count (frame_count),
    .frame_addr  (frame_addr),
    .frame_wdata (frame_wdata),
    .frame_oe    (frame_oe)
  );

  bind byte_bus_sequencer cpuhandler_asserts asserts_i (
    .clk    (clk),
    .reset  (reset),
    .phase  (phase),
    .step   (step),
    .uio_oe (uio_oe)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic word_t encode(input opcode_t op, input logic [23:0] operand);
    return {op, operand};
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s is 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  // Memory is refilled while reset is held, the program is loaded after this
  task automatic begin_reset();
    @(posedge clk);
    reset <= 1'b1;
    mem_i.clear_memory();
  endtask

  task automatic end_reset();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic next_frame(output word_t addr, output byte_t oe, output word_t wdata,
                            output bit ok);
    int seen;
    int waited;
    seen   = frame_count;
    waited = 0;
    ok     = 1'b0;
    while (!ok && waited < 20) begin
      @(posedge clk);
      waited++;
      ok = (frame_count != seen);
    end
    addr  = frame_addr;
    oe    = frame_oe;
    wdata = frame_wdata;
    if (!ok) begin
      timeouts++;
      $display("Timeout: no bus frame completed within 20 cycles");
    end
  endtask

  // Runs until a write frame to 0x100, counting read frames at watch_addr
  task automatic wait_store(input word_t watch_addr, output word_t data, output int hits);
    word_t addr;
    byte_t oe;
    word_t wdata;
    bit    got_frame;
    bit    done;
    int    frames;
    hits      = 0;
    data      = '0;
    done      = 1'b0;
    got_frame = 1'b1;
    frames    = 0;
    while (!done && got_frame && frames < 400) begin
      next_frame(addr, oe, wdata, got_frame);
      frames++;
      if (addr == watch_addr && oe == 8'h00) hits++;
      if (addr == 32'h100 && oe == 8'hff) begin
        done = 1'b1;
        data = wdata;
      end
    end
    if (!done && got_frame) begin
      timeouts++;
      $display("Timeout: the program never stored to address 0x100");
    end
  endtask

  task automatic test_reset_state();
    word_t addr;
    byte_t oe;
    word_t wdata;
    bit    ok;
    begin_reset();
    mem_i.load_word(32'h0, encode(HALT, 24'h0));
    end_reset();
    check_byte("uo_out after reset", uo_out, 8'h00);
    check_byte("uio_out after reset", uio_out, 8'h00);
    check_byte("uio_oe after reset", uio_oe, 8'h00);
    next_frame(addr, oe, wdata, ok);
    check_word("first frame address", addr, 32'h0);  // First fetch reads address 0
    check_byte("first frame uio_oe", oe, 8'h00);
  endtask

  task automatic test_alu_program();
    word_t exp;
    word_t data;
    int    hits;
    begin_reset();
    mem_i.load_word(32'h0, encode(LDI, 24'h12_3456));
    mem_i.load_word(32'h1, encode(ADD, 24'h80));
    mem_i.load_word(32'h2, encode(SUB, 24'h81));
    mem_i.load_word(32'h3, encode(AND, 24'h82));
    mem_i.load_word(32'h4, encode(XOR, 24'h83));
    mem_i.load_word(32'h5, encode(ST, 24'h100));
    mem_i.load_word(32'h6, encode(HALT, 24'h0));
    mem_i.load_word(32'h80, 32'hfedc_ba98);
    mem_i.load_word(32'h81, 32'h0101_0101);
    mem_i.load_word(32'h82, 32'hf0f0_ff0f);
    mem_i.load_word(32'h83, 32'h1234_5678);
    end_reset();
    exp = 32'h0012_3456;  // LDI zero-extends the operand
    exp = exp + 32'hfedc_ba98;
    exp = exp - 32'h0101_0101;
    exp = exp & 32'hf0f0_ff0f;
    exp = exp ^ 32'h1234_5678;
    wait_store(32'h80, data, hits);
    check_word("alu result", data, exp);
    check_word("ADD operand reads", word_t'(hits), 32'd1);
  endtask

  task automatic test_load_store();
    word_t exp_addr [7];
    byte_t exp_oe [7];
    word_t addr;
    byte_t oe;
    word_t wdata;
    bit    ok;
    // Fetch LD, read operand, fetch ST, write, fetch HALT, then idle reads at pc 2
    exp_addr = '{32'h0, 32'h90, 32'h1, 32'h100, 32'h2, 32'h2, 32'h2};
    exp_oe   = '{8'h00, 8'h00, 8'h00, 8'hff, 8'h00, 8'h00, 8'h00};
    begin_reset();
    mem_i.load_word(32'h0, encode(LD, 24'h90));
    mem_i.load_word(32'h1, encode(ST, 24'h100));
    mem_i.load_word(32'h2, encode(HALT, 24'h0));
    mem_i.load_word(32'h90, 32'hc0ff_ee42);
    end_reset();
    for (int i = 0; i < 7; i++) begin
      next_frame(addr, oe, wdata, ok);
      check_word($sformatf("frame %0d address", i), addr, exp_addr[i]);
      check_byte($sformatf("frame %0d uio_oe", i), oe, exp_oe[i]);
      if (i == 3) check_word("stored word", wdata, 32'hc0ff_ee42);
    end
    check_word("memory at 0x100", mem_i.read_word(32'h100), 32'hc0ff_ee42);
  endtask

  task automatic test_countdown_loop();
    word_t data;
    int    hits;
    begin_reset();
    mem_i.load_word(32'h0, encode(LD, 24'h80));
    mem_i.load_word(32'h1, encode(JZ, 24'h4));   // Taken only once acc reaches zero
    mem_i.load_word(32'h2, encode(SUB, 24'h81));
    mem_i.load_word(32'h3, encode(JMP, 24'h1));
    mem_i.load_word(32'h4, encode(ST, 24'h101));
    mem_i.load_word(32'h5, encode(LDI, 24'h00_beef));
    mem_i.load_word(32'h6, encode(ST, 24'h100));
    mem_i.load_word(32'h7, encode(HALT, 24'h0));
    mem_i.load_word(32'h80, 32'd6);
    mem_i.load_word(32'h81, 32'd1);
    end_reset();
    wait_store(32'h81, data, hits);
    check_word("loop marker", data, 32'h0000_beef);
    check_word("SUB operand reads", word_t'(hits), 32'd6);  // One per untaken JZ
    check_word("acc at loop exit", mem_i.read_word(32'h101), 32'h0);
  endtask

  task automatic test_halt();
    word_t data;
    int    hits;
    word_t addr;
    byte_t oe;
    word_t wdata;
    bit    ok;
    begin_reset();
    mem_i.load_word(32'h0, encode(LDI, 24'h00_0a5c));
    mem_i.load_word(32'h1, encode(ST, 24'h100));
    mem_i.load_word(32'h2, encode(HALT, 24'h0));
    mem_i.load_word(32'h3, encode(ST, 24'h101));  // Must never run
    end_reset();
    wait_store(32'h0, data, hits);
    check_word("value before halt", data, 32'h0000_0a5c);
    check_word("reads at pc 0", word_t'(hits), 32'd2);  // Fetch plus the LDI idle read
    for (int i = 0; i < 6; i++) begin
      next_frame(addr, oe, wdata, ok);
      check_word($sformatf("halted frame %0d address", i), addr, 32'h2);
      check_byte($sformatf("halted frame %0d uio_oe", i), oe, 8'h00);
    end
  endtask

  task automatic test_random_add();
    word_t imm;
    word_t operand;
    word_t data;
    int    hits;
    for (int round = 0; round < 4; round++) begin
      imm     = $urandom;
      operand = $urandom;
      begin_reset();
      mem_i.load_word(32'h0, encode(LDI, imm[23:0]));
      mem_i.load_word(32'h1, encode(ADD, 24'h80));
      mem_i.load_word(32'h2, encode(ST, 24'h100));
      mem_i.load_word(32'h3, encode(HALT, 24'h0));
      mem_i.load_word(32'h80, operand);
      end_reset();
      wait_store(32'h80, data, hits);
      check_word($sformatf("random sum %0d", round), data, {8'h00, imm[23:0]} + operand);
      check_word($sformatf("random operand reads %0d", round), word_t'(hits), 32'd1);
    end
  endtask

  initial begin
    errors   = 0;
    checks   = 0;
    timeouts = 0;
    reset <= 1'b1;
    ui_in <= '0;
    ena   <= 1'b1;
    void'($urandom(32'h2f10_50a7));
    test_reset_state();
    test_alu_program();
    test_load_store();
    test_countdown_loop();
    test_halt();
    test_random_add();
    assert_failures = dut_i.seq_i.asserts_i.failures;
    $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
             checks, errors, timeouts, assert_failures);
    if (errors == 0 && timeouts == 0 && assert_failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
